//--- rtl/mcu8_pkg.sv
package mcu8_pkg;

   //////////////////////////////////////////////////
   // widths
   //////////////////////////////////////////////////
   typedef logic [17:0] inst_t;      // instruction word
   typedef logic [11:0] pc_t;        // program address
   typedef logic [7:0]  data_t;      // register / port value
   typedef logic [3:0]  reg_addr_t;  // s0..sF
   typedef logic [5:0]  op_t;        // instruction[17:12]
   typedef logic [4:0]  stack_ptr_t;

   // data ops, register form (lsb set gives the kk form)
   localparam op_t OP_LOAD      = 6'h00;
   localparam op_t OP_AND       = 6'h02;
   localparam op_t OP_OR        = 6'h04;
   localparam op_t OP_XOR       = 6'h06;
   localparam op_t OP_INPUT     = 6'h08;
   localparam op_t OP_ADD       = 6'h10;
   localparam op_t OP_ADDCY     = 6'h12;
   localparam op_t OP_SUB       = 6'h18;
   localparam op_t OP_SUBCY     = 6'h1A;
   localparam op_t OP_COMPARE   = 6'h1C;
   localparam op_t OP_COMPARECY = 6'h1E;
   localparam op_t OP_OUTPUT    = 6'h2C;

   //////////////////////////////////////////////////
   // program flow
   //////////////////////////////////////////////////
   localparam op_t OP_JUMP      = 6'h22;
   localparam op_t OP_CALL      = 6'h20;
   localparam op_t OP_RETURN    = 6'h25;

   // opcode bits [3:2] select the condition
   localparam op_t OP_JUMP_Z    = 6'h32;
   localparam op_t OP_JUMP_NZ   = 6'h36;
   localparam op_t OP_JUMP_C    = 6'h3A;
   localparam op_t OP_JUMP_NC   = 6'h3E;

   localparam op_t OP_CALL_Z    = 6'h30;
   localparam op_t OP_CALL_NZ   = 6'h34;
   localparam op_t OP_CALL_C    = 6'h38;
   localparam op_t OP_CALL_NC   = 6'h3C;

   localparam op_t OP_RETURN_Z  = 6'h31;
   localparam op_t OP_RETURN_NZ = 6'h35;
   localparam op_t OP_RETURN_C  = 6'h39;
   localparam op_t OP_RETURN_NC = 6'h3D;

   localparam logic [1:0] COND_Z  = 2'b00;
   localparam logic [1:0] COND_NZ = 2'b01;
   localparam logic [1:0] COND_C  = 2'b10;
   localparam logic [1:0] COND_NC = 2'b11;

   // call stack
   localparam stack_ptr_t STACK_DEPTH = 5'd31;
   localparam pc_t        RESET_PC    = 12'h000;

   // one instruction every two clocks
   typedef enum logic
   {
      ph_fetch,
      ph_exec
   } phase_t;

endpackage

//--- rtl/mcu8_dec_if.sv
`timescale 1ns/1ps

interface mcu8_dec_if import mcu8_pkg::*; ();

   // data path fields
   op_t        alu_op;
   logic       use_const;   // second operand is kk
   logic       use_carry;   // ADDCY / SUBCY / COMPARECY
   logic       writes_sx;
   logic       is_input;
   logic       is_output;
   reg_addr_t  sx;
   reg_addr_t  sy;
   data_t      kk;

   // flow fields
   pc_t        target;
   logic       is_jump;
   logic       is_call;
   logic       is_return;
   logic       cond_en;
   logic [1:0] cond_sel;    // z, nz, c, nc

   modport decoder (output alu_op, use_const, use_carry, writes_sx, is_input, is_output,
                    sx, sy, kk, target, is_jump, is_call, is_return, cond_en, cond_sel);

   modport alu (input alu_op, use_const, use_carry, writes_sx, is_input, is_output, sx, kk);

   modport seq (input target, is_jump, is_call, is_return, cond_en, cond_sel);

endinterface

//--- rtl/mcu8_decoder.sv
`timescale 1ns/1ps

module mcu8_decoder import mcu8_pkg::*;
(
   input  inst_t          instruction,
   mcu8_dec_if.decoder    dec
);

   op_t op;
   op_t op_reg;   // opcode with the kk bit cleared

   assign op     = instruction[17:12];
   assign op_reg = {op[5:1], 1'b0};

   // operand fields
   assign dec.sx        = instruction[11:8];
   assign dec.sy        = instruction[7:4];
   assign dec.kk        = instruction[7:0];
   assign dec.target    = instruction[11:0];
   assign dec.use_const = op[0];
   assign dec.cond_sel  = op[3:2];  // same encoding for jump, call and return

   //////////////////////////////////////////////////
   // data ops
   //////////////////////////////////////////////////
   always_comb
   begin
      dec.alu_op    = OP_LOAD;  // neutral for flow ops
      dec.writes_sx = 1'b0;
      dec.is_input  = 1'b0;
      dec.is_output = 1'b0;
      case (op_reg)
         OP_LOAD, OP_AND, OP_OR, OP_XOR, OP_ADD, OP_ADDCY, OP_SUB, OP_SUBCY:
         begin
            dec.alu_op    = op_reg;
            dec.writes_sx = 1'b1;
         end
         OP_COMPARE, OP_COMPARECY:
            dec.alu_op = op_reg;  // flags only
         OP_INPUT:
         begin
            dec.alu_op    = op_reg;
            dec.writes_sx = 1'b1;
            dec.is_input  = 1'b1;
         end
         OP_OUTPUT:
         begin
            dec.alu_op    = op_reg;
            dec.is_output = 1'b1;
         end
         default: ;
      endcase
   end

   assign dec.use_carry = (op_reg == OP_ADDCY) || (op_reg == OP_SUBCY) ||
                          (op_reg == OP_COMPARECY);

   //////////////////////////////////////////////////
   // program flow
   //////////////////////////////////////////////////
   always_comb
   begin
      dec.is_jump   = 1'b0;
      dec.is_call   = 1'b0;
      dec.is_return = 1'b0;
      dec.cond_en   = 1'b0;
      case (op)
         OP_JUMP:   dec.is_jump   = 1'b1;
         OP_CALL:   dec.is_call   = 1'b1;
         OP_RETURN: dec.is_return = 1'b1;
         OP_JUMP_Z, OP_JUMP_NZ, OP_JUMP_C, OP_JUMP_NC:
         begin
            dec.is_jump = 1'b1;
            dec.cond_en = 1'b1;
         end
         OP_CALL_Z, OP_CALL_NZ, OP_CALL_C, OP_CALL_NC:
         begin
            dec.is_call = 1'b1;
            dec.cond_en = 1'b1;
         end
         OP_RETURN_Z, OP_RETURN_NZ, OP_RETURN_C, OP_RETURN_NC:
         begin
            dec.is_return = 1'b1;
            dec.cond_en   = 1'b1;
         end
         default: ;
      endcase
   end

endmodule

//--- rtl/mcu8_regfile.sv
`timescale 1ns/1ps

module mcu8_regfile import mcu8_pkg::*;
(
   input  logic       clk,
   input  reg_addr_t  rd_a,
   input  reg_addr_t  rd_b,
   output data_t      rd_a_data,
   output data_t      rd_b_data,
   input  logic       wr_en,
   input  reg_addr_t  wr_addr,
   input  data_t      wr_data
);

   data_t regs [2 ** $bits(reg_addr_t)];  // s0..sF

   // both reads are combinational in the decode cycle
   assign rd_a_data = regs[rd_a];  // sx
   assign rd_b_data = regs[rd_b];  // sy

   // write-back at the end of the cycle after decode
   always_ff @(posedge clk)
   begin
      if (wr_en)
      begin
         regs[wr_addr] <= wr_data;
      end
   end

endmodule

//--- rtl/mcu8_alu.sv
`timescale 1ns/1ps

module mcu8_alu import mcu8_pkg::*;
(
   input  logic       clk,
   input  logic       rst,
   input  logic       decode_phase,
   input  logic       wb_phase,
   mcu8_dec_if.alu    dec,
   input  data_t      sx_data,
   input  data_t      sy_data,
   input  data_t      in_port,
   output logic       wr_en,
   output reg_addr_t  wr_addr,
   output data_t      wr_data,
   output data_t      out_port,
   output data_t      port_id,
   output logic       write_strobe,
   output logic       read_strobe,
   output logic       z_flag,
   output logic       c_flag
);

   data_t      opnd;
   logic       cin;
   logic [8:0] calc;     // bit 8 is carry or borrow
   logic       flag_op;
   logic       z_calc;

   // decode -> write-back stage
   data_t      res_q;
   data_t      port_q;
   logic       c_q;
   logic       z_q;
   logic       in_q;
   logic       wr_q;
   logic       upd_q;

   //////////////////////////////////////////////////
   // decode cycle
   //////////////////////////////////////////////////
   assign opnd = dec.use_const ? dec.kk : sy_data;
   assign cin  = dec.use_carry & c_flag;

   always_comb
   begin
      flag_op = 1'b1;
      case (dec.alu_op)
         OP_AND: calc = {1'b0, sx_data & opnd};  // logic ops clear C
         OP_OR:  calc = {1'b0, sx_data | opnd};
         OP_XOR: calc = {1'b0, sx_data ^ opnd};
         OP_ADD, OP_ADDCY:
            calc = {1'b0, sx_data} + {1'b0, opnd} + {8'd0, cin};
         OP_SUB, OP_SUBCY, OP_COMPARE, OP_COMPARECY:
            calc = {1'b0, sx_data} - {1'b0, opnd} - {8'd0, cin};
         default:
         begin
            calc    = {1'b0, opnd};  // load, flags untouched
            flag_op = 1'b0;
         end
      endcase
   end

   // carry forms keep Z only if the lower byte was zero too
   assign z_calc = (calc[7:0] == 8'h00) & (~dec.use_carry | z_flag);

   assign read_strobe = decode_phase & dec.is_input;
   assign port_id     = decode_phase ? opnd : port_q;

   always_ff @(posedge clk)
   begin
      if (decode_phase)
      begin
         res_q    <= calc[7:0];
         c_q      <= calc[8];
         z_q      <= z_calc;
         in_q     <= dec.is_input;
         wr_addr  <= dec.sx;
         port_q   <= opnd;
         out_port <= sx_data;
      end
   end

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         wr_q         <= 1'b0;
         upd_q        <= 1'b0;
         write_strobe <= 1'b0;
      end
      else
      begin
         write_strobe <= decode_phase & dec.is_output;  // single cycle
         if (decode_phase)
         begin
            wr_q  <= dec.writes_sx;
            upd_q <= flag_op;
         end
      end
   end

   //////////////////////////////////////////////////
   // write-back cycle
   //////////////////////////////////////////////////
   assign wr_en   = wb_phase & wr_q;
   assign wr_data = in_q ? in_port : res_q;  // in_port sampled here

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         c_flag <= 1'b0;
         z_flag <= 1'b0;
      end
      else if (wb_phase && upd_q)
      begin
         c_flag <= c_q;
         z_flag <= z_q;
      end
   end

   // output strobe of one instruction must not meet the input strobe of the next
   assert property (@(posedge clk) disable iff (rst) !(write_strobe && read_strobe));

endmodule

//--- rtl/mcu8_sequencer.sv
`timescale 1ns/1ps

module mcu8_sequencer import mcu8_pkg::*;
(
   input  logic       clk,
   input  logic       rst,
   mcu8_dec_if.seq    dec,
   input  logic       z_flag,
   input  logic       c_flag,
   output pc_t        address,
   output logic       bram_enable,
   output logic       decode_phase,
   output logic       wb_phase,
   output logic       fault_restart
);

   phase_t     phase;
   pc_t        pc;
   pc_t        pc_up;
   stack_ptr_t sp;        // number of entries in use
   stack_ptr_t sp_up;
   stack_ptr_t sp_dn;
   logic       cond_true;
   logic       go;
   logic       do_jump;
   logic       do_call;
   logic       do_ret;
   logic       full;
   logic       empty;

   pc_t stack_mem [STACK_DEPTH];  // return addresses

   assign address     = pc;
   assign bram_enable = (phase == ph_fetch);
   assign pc_up       = pc + 12'd1;
   assign sp_up       = sp + 5'd1;
   assign sp_dn       = sp - 5'd1;
   assign full        = (sp == STACK_DEPTH);
   assign empty       = (sp == 5'd0);

   //////////////////////////////////////////////////
   // branch condition
   //////////////////////////////////////////////////
   always_comb
   begin
      case (dec.cond_sel)
         COND_Z:  cond_true = z_flag;
         COND_NZ: cond_true = ~z_flag;
         COND_C:  cond_true = c_flag;
         COND_NC: cond_true = ~c_flag;
         default: cond_true = 1'b0;
      endcase
   end

   assign go      = ~dec.cond_en | cond_true;
   assign do_jump = dec.is_jump & go;
   assign do_call = dec.is_call & go;
   assign do_ret  = dec.is_return & go;

   // stack misuse restarts the whole core
   assign fault_restart = decode_phase & ((do_call & full) | (do_ret & empty));

   //////////////////////////////////////////////////
   // phase and pc
   //////////////////////////////////////////////////
   always_ff @(posedge clk)
   begin
      if (rst || fault_restart)
      begin
         phase        <= ph_exec;  // one idle cycle before the first fetch
         decode_phase <= 1'b0;
         wb_phase     <= 1'b0;
         pc           <= RESET_PC;
         sp           <= 5'd0;
      end
      else
      begin
         phase        <= (phase == ph_fetch) ? ph_exec : ph_fetch;
         decode_phase <= bram_enable;
         wb_phase     <= decode_phase;
         if (decode_phase)
         begin
            if (do_call)
            begin
               pc <= dec.target;
               sp <= sp_up;
            end
            else if (do_ret)
            begin
               pc <= stack_mem[sp_dn];
               sp <= sp_dn;
            end
            else if (do_jump)
               pc <= dec.target;
            else
               pc <= pc_up;
         end
      end
   end

   // push the address after the call
   always_ff @(posedge clk)
   begin
      if (decode_phase && do_call && !full)
      begin
         stack_mem[sp] <= pc_up;
      end
   end

   // the pointer never wraps past a full stack
   assert property (@(posedge clk) disable iff (rst) (full && !fault_restart) |=> !empty);

endmodule

//--- rtl/mcu8_core.sv
`timescale 1ns/1ps

module mcu8_core import mcu8_pkg::*;
(
   input  logic   clk,
   input  logic   rst,
   output pc_t    address,
   input  inst_t  instruction,
   output logic   bram_enable,
   input  data_t  in_port,
   output data_t  out_port,
   output data_t  port_id,
   output logic   write_strobe,
   output logic   read_strobe
);

   mcu8_dec_if dec_if ();

   data_t     sx_data;
   data_t     sy_data;
   logic      wr_en;
   reg_addr_t wr_addr;
   data_t     wr_data;
   logic      z_flag;
   logic      c_flag;
   logic      decode_phase;
   logic      wb_phase;
   logic      fault_restart;
   logic      alu_rst;

   assign alu_rst = rst | fault_restart;  // stack fault also clears flags

   //////////////////////////////////////////////////
   // decode and data path
   //////////////////////////////////////////////////
   mcu8_decoder u_decoder (
      .instruction (instruction),
      .dec         (dec_if.decoder)
   );

   mcu8_regfile u_regfile (
      .clk       (clk),
      .rd_a      (dec_if.sx),
      .rd_b      (dec_if.sy),
      .rd_a_data (sx_data),
      .rd_b_data (sy_data),
      .wr_en     (wr_en),
      .wr_addr   (wr_addr),
      .wr_data   (wr_data)
   );

   mcu8_alu u_alu (
      .clk          (clk),
      .rst          (alu_rst),
      .decode_phase (decode_phase),
      .wb_phase     (wb_phase),
      .dec          (dec_if.alu),
      .sx_data      (sx_data),
      .sy_data      (sy_data),
      .in_port      (in_port),
      .wr_en        (wr_en),
      .wr_addr      (wr_addr),
      .wr_data      (wr_data),
      .out_port     (out_port),
      .port_id      (port_id),
      .write_strobe (write_strobe),
      .read_strobe  (read_strobe),
      .z_flag       (z_flag),
      .c_flag       (c_flag)
   );

   // program counter and call stack
   mcu8_sequencer u_sequencer (
      .clk           (clk),
      .rst           (rst),
      .dec           (dec_if.seq),
      .z_flag        (z_flag),
      .c_flag        (c_flag),
      .address       (address),
      .bram_enable   (bram_enable),
      .decode_phase  (decode_phase),
      .wb_phase      (wb_phase),
      .fault_restart (fault_restart)
   );

endmodule

//--- tests/mcu8_prog.svh
`ifndef MCU8_PROG_SVH
`define MCU8_PROG_SVH

//////////////////////////////////////////////////
// program words, {opcode[5:0], sx, kk} at address 0
//////////////////////////////////////////////////
localparam int MAIN_LEN = 49;
localparam logic [17:0] MAIN_PROG [0:48] = '{
   18'h0105A, 18'h2D001, 18'h0300F, 18'h2D002,  // load, and kk
   18'h011F0, 18'h04010, 18'h2D003, 18'h070FF,  // or sy, xor kk
   18'h2D004, 18'h02100, 18'h00210, 18'h06200,  // and / load / xor sy
   18'h2D205, 18'h013F0, 18'h11320, 18'h01400,  // add across the wrap
   18'h13400, 18'h2D306, 18'h2D407, 18'h01510,
   18'h19520, 18'h01605, 18'h1B605, 18'h2D508,  // sub below zero
   18'h2D609, 18'h1D005, 18'h3201C, 18'h2D0FF,  // jump z over a bad write
   18'h1D006, 18'h3A01F, 18'h2D0FF, 18'h017A5,  // jump c
   18'h2D70A, 18'h1D004, 18'h1F005, 18'h36025,  // comparecy keeps z clear
   18'h2D0FF, 18'h1D005, 18'h1F005, 18'h36029,  // comparecy keeps z set
   18'h2D70B, 18'h3E02B, 18'h2D0FF, 18'h09930,  // input from port 30
   18'h11901, 18'h2D90C, 18'h20040, 18'h2D70D,  // call the outer sub
   18'h22048
};

// outer sub at 0x40, inner at 0x44, self call at 0x48
localparam int          SUB_LEN  = 9;
localparam logic [11:0] SUB_BASE = 12'h040;
localparam logic [17:0] SUB_PROG [0:8] = '{
   18'h2D010, 18'h20044, 18'h2D011, 18'h25000,
   18'h1D005, 18'h35000, 18'h2D012, 18'h31000,
   18'h20048
};

//////////////////////////////////////////////////
// port traffic in order
// columns: read flag, port_id, out_port or in_port value
//////////////////////////////////////////////////
localparam int NUM_ROWS = 18;
localparam logic [16:0] ROWS [0:17] = '{
   {1'b0, 8'h01, 8'h5A}, {1'b0, 8'h02, 8'h0A}, {1'b0, 8'h03, 8'hFA},
   {1'b0, 8'h04, 8'h05}, {1'b0, 8'h05, 8'h05}, {1'b0, 8'h06, 8'h10},
   {1'b0, 8'h07, 8'h01}, {1'b0, 8'h08, 8'hF0}, {1'b0, 8'h09, 8'hFF},
   {1'b0, 8'h0A, 8'hA5}, {1'b0, 8'h0B, 8'hA5}, {1'b1, 8'h30, 8'h3C},
   {1'b0, 8'h0C, 8'h3D}, {1'b0, 8'h10, 8'h05}, {1'b0, 8'h12, 8'h05},
   {1'b0, 8'h11, 8'h05}, {1'b0, 8'h0D, 8'hA5},
   {1'b0, 8'h01, 8'h5A}   // first write again after the stack overflow
};

`endif

//--- tests/mcu8_tb.sv
`timescale 1ns/1ps

module mcu8_tb;

   `include "mcu8_prog.svh"

   localparam int CYCLE_LIMIT = NUM_ROWS * 64;

   logic        clk = 1'b0;
   logic        rst;
   logic [11:0] address;
   logic [17:0] instruction;
   logic        bram_enable;
   logic [7:0]  in_port;
   logic [7:0]  out_port;
   logic [7:0]  port_id;
   logic        write_strobe;
   logic        read_strobe;

   logic [17:0] mem [0:4095];  // program memory model
   int          cycles       = 0;
   int          errors       = 0;
   int          checks       = 0;
   int          zero_fetches = 0;

   mcu8_core UUT (
      .clk          (clk),
      .rst          (rst),
      .address      (address),
      .instruction  (instruction),
      .bram_enable  (bram_enable),
      .in_port      (in_port),
      .out_port     (out_port),
      .port_id      (port_id),
      .write_strobe (write_strobe),
      .read_strobe  (read_strobe)
   );

   initial
   begin
      forever #20 clk = ~clk;
   end

   task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
      checks++;
      if (got !== exp)
      begin
         errors++;
         $display("ERR %s: got %h expected %h", name, got, exp);
      end
   endtask

   //////////////////////////////////////////////////
   // memory answers on the falling edge of the fetch cycle
   //////////////////////////////////////////////////
   always @(negedge clk)
   begin
      if (bram_enable)
         instruction <= mem[address];
      if (!rst && bram_enable && address == 12'h000)
         zero_fetches++;  // start and restart
   end

   always @(posedge clk)
   begin
      cycles++;
      if (cycles > CYCLE_LIMIT)
      begin
         $display("timeout after %0d cycles, port traffic stopped early", cycles);
         $display("Simulation failed");
         $finish;
      end
   end

   initial
   begin
      logic [16:0] row;
      int          errs_before;

      rst         = 1'b1;
      instruction = '0;
      in_port     = '0;

      // unused words jump to themselves
      for (int a = 0; a < 4096; a++)
         mem[a] = {6'h22, a[11:0]};
      for (int i = 0; i < MAIN_LEN; i++)
         mem[i] = MAIN_PROG[i];
      for (int i = 0; i < SUB_LEN; i++)
         mem[int'(SUB_BASE) + i] = SUB_PROG[i];

      repeat (4)
      begin
         @(negedge clk);
         check("write_strobe", 32'(write_strobe), 32'h0);
         check("read_strobe", 32'(read_strobe), 32'h0);
         check("bram_enable", 32'(bram_enable), 32'h0);
      end
      rst = 1'b0;

      do
         @(negedge clk);
      while (!bram_enable);
      check("address", 32'(address), 32'h0);
      $display("reset: %s", (errors == 0) ? "ok" : "mismatch");

      //////////////////////////////////////////////////
      // walk the port traffic table
      //////////////////////////////////////////////////
      for (int r = 0; r < NUM_ROWS; r++)
      begin
         row         = ROWS[r];
         errs_before = errors;
         do
            @(negedge clk);
         while (!write_strobe && !read_strobe);
         if (row[16])
         begin
            if (!read_strobe)
            begin
               errors++;
               $display("row %0d: expected a port read but the core wrote a port", r);
            end
            else
            begin
               check("port_id", 32'(port_id), 32'(row[15:8]));
               in_port = row[7:0];  // held through write-back
            end
         end
         else if (!write_strobe)
         begin
            errors++;
            $display("row %0d: expected a port write but the core read a port", r);
         end
         else
         begin
            check("port_id", 32'(port_id), 32'(row[15:8]));
            check("out_port", 32'(out_port), 32'(row[7:0]));
         end
         $display("row %0d: %s", r, (errors == errs_before) ? "ok" : "mismatch");
      end

      check("fetches at address 0", 32'(zero_fetches), 32'd2);
      $display("%0d rows, %0d checks, %0d errors", NUM_ROWS, checks, errors);
      if (errors == 0)
         $display("Simulation passed");
      else
         $display("Simulation failed");
      $finish;
   end

endmodule

//--- src.f
+incdir+tests
rtl/mcu8_pkg.sv
rtl/mcu8_dec_if.sv
rtl/mcu8_decoder.sv
rtl/mcu8_regfile.sv
rtl/mcu8_alu.sv
rtl/mcu8_sequencer.sv
rtl/mcu8_core.sv
tests/mcu8_tb.sv

//--- Makefile
# Verilator simulation of the mcu8 testbench

VERILATOR ?= verilator
TOP       ?= mcu8_tb
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_TEXT ?= Simulation passed

.PHONY: sim clean

# the grep decides the exit status of the run
sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee /dev/stderr | grep -qF "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)
